// ==== build.f ====
hdl/rob_pkg.sv
hdl/dispatch_stage.sv
hdl/rob_bank.sv
hdl/rob.sv
hdl/commit_stage.sv
hdl/rob_top.sv
dv/rob_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the reorder buffer testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rob_tb -f build.f -o rob_sim
./obj_dir/rob_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation ok"

// ==== dv/rob_tb.sv ====
// ==========================================================================
// Testbench for the reorder buffer top level.
// Clock, reset, step table, reference model of rows, tags and kills,
// commit and tag monitor, value check and timeout.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

	typedef enum {S_RESET, S_DIS, S_WB, S_KILL, S_STALL, S_IDLE, S_FULL, S_DRAIN} step_e;

	typedef struct {
		string name;
		step_e kind;
		int    a;
		int    b;
	} step_t;

	localparam int DEPTH = 3;
	localparam int ROWS  = 2 ** DEPTH;
	localparam int NSTEP = 22;
	localparam int LIMIT = NSTEP * 20 + 16;

	// DIS operands are a bundle count and a branch slot mask.
	// WB leaves a number of writebacks, KILL goes back a number of tags.
	// IDLE waits a number of cycles and then expects the given o_com_valid.
	step_t steps [NSTEP] = '{
		'{"after_reset", S_RESET, 0, 0},
		'{"order_dis", S_DIS, 6, 0},
		'{"order_wb", S_WB, 0, 0},
		'{"busy_dis", S_DIS, 1, 0},
		'{"busy_wb", S_WB, 1, 0},
		'{"busy_hold", S_IDLE, 12, 0},
		'{"busy_last", S_WB, 0, 0},
		'{"full_dis", S_DIS, 9, 2},
		'{"full_ready", S_FULL, 0, 0},
		'{"full_wb", S_WB, 0, 0},
		'{"kill_dis", S_DIS, 4, 1},
		'{"kill_br", S_KILL, 2, 0},
		'{"kill_wb", S_WB, 0, 0},
		'{"wrap_dis", S_DIS, 4, 5},
		'{"wrap_kill", S_KILL, 5, 0},
		'{"wrap_wb", S_WB, 0, 0},
		'{"bp_dis", S_DIS, 5, 0},
		'{"bp_stall", S_STALL, 1, 0},
		'{"bp_wb", S_WB, 0, 0},
		'{"bp_hold", S_IDLE, 15, 1},
		'{"bp_release", S_STALL, 0, 0},
		'{"bp_drain", S_DRAIN, 0, 0}
	};

	logic clk, rst, dis_valid, wb_valid, kill_valid, com_ready;
	logic dis_ready, tag_valid, com_valid;
	rob_pkg::dis_slot_t [rob_pkg::NBANK-1:0] dis_slots;
	logic [DEPTH-1:0]                        dis_tag;
	logic [DEPTH-1:0]                        wb_row;
	logic [1:0]                              wb_slot;
	logic [rob_pkg::BRM_W-1:0]               kill_tag;
	rob_pkg::com_row_t                       com_row;

	// Expected rows in dispatch order, their slot tags and pending writebacks.
	rob_pkg::com_row_t         exp_q [$];
	logic [15:0]               tag_q [$];
	int                        wb_q  [$];
	logic [rob_pkg::BRM_W-1:0] brcnt = '0;
	int n_disp = 0, n_written = 0, n_commit = 0;
	int cycles = 0, errors = 0, checks = 0;
	int seed = 24;
	string cur_name = "init";
	logic held = 1'b0;
	rob_pkg::com_row_t held_row;

	rob_top #(.WIDTH_BANK(DEPTH)) dut (
		.i_clk(clk), .i_rst(rst), .i_dis_valid(dis_valid), .o_dis_ready(dis_ready),
		.i_dis_slots(dis_slots), .o_dis_tag(dis_tag), .o_dis_tag_valid(tag_valid),
		.i_wb_valid(wb_valid), .i_wb_row(wb_row), .i_wb_slot(wb_slot),
		.i_kill_valid(kill_valid), .i_kill_tag(kill_tag), .o_com_valid(com_valid),
		.i_com_ready(com_ready), .o_com_row(com_row)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	// Tag lies after k, up to and including last. Equal tags cover the whole ring.
	function automatic bit tag_killed(input logic [3:0] k, input logic [3:0] last,
			input logic [3:0] t);
		logic [3:0] d;
		logic [3:0] n;
		d = t - k;
		n = last - k;
		return (n == 0) || (d != 0 && d <= n);
	endfunction

	function automatic rob_pkg::com_row_t masked(input rob_pkg::com_row_t row);
		rob_pkg::com_row_t m;
		m = row;
		for (int s = 0; s < rob_pkg::NBANK; s++) begin
			if (!row.mask[s]) m.prd[s] = '0;
		end
		return m;
	endfunction

	task automatic send_bundles(input int n, input logic [3:0] br);
		rob_pkg::com_row_t row;
		logic [15:0]       tags;
		logic [3:0]        val;
		for (int i = 0; i < n; i++) begin
			val = 4'($random(seed)) | br;
			if (val == 4'b0000) val = 4'b0001;
			for (int s = 0; s < rob_pkg::NBANK; s++) begin
				dis_slots[s].val = val[s];
				dis_slots[s].op  = br[s] ? rob_pkg::OP_BRANCH :
					(($random(seed) & 1) ? rob_pkg::OP_LOAD : rob_pkg::OP_ALU);
				dis_slots[s].prd = 7'($random(seed));
				row.mask[s]      = val[s];
				row.prd[s]       = dis_slots[s].prd;
				tags[s*4 +: 4]   = brcnt;
				// A branch bumps the tag for the slots after it.
				if (val[s] && br[s]) brcnt = brcnt + 1'b1;
				if (val[s]) wb_q.push_back(n_disp * 4 + s);
			end
			exp_q.push_back(masked(row));
			tag_q.push_back(tags);
			dis_valid = 1'b1;
			do @(negedge clk); while (!dis_ready);
			@(posedge clk);
			#2;
			n_disp++;
		end
		dis_valid = 1'b0;
	endtask

	task automatic send_writebacks(input int leave);
		int j;
		int tmp;
		for (int i = wb_q.size() - 1; i > 0; i--) begin
			j = int'($unsigned($random(seed)) % (i + 1));
			tmp = wb_q[i];
			wb_q[i] = wb_q[j];
			wb_q[j] = tmp;
		end
		// Only rows already written to the ring can take a writeback.
		while (wb_q.size() > leave) begin
			j = 0;
			while (j < wb_q.size() && wb_q[j] / 4 >= n_written) j++;
			wb_valid = (j < wb_q.size());
			if (wb_valid) begin
				wb_row  = DEPTH'((wb_q[j] / 4) % ROWS);
				wb_slot = 2'(wb_q[j] % 4);
				wb_q.delete(j);
			end
			@(posedge clk);
			#2;
		end
		wb_valid = 1'b0;
		while (leave == 0 && com_ready && exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_kill(input int back);
		logic [3:0]        ktag;
		rob_pkg::com_row_t row;
		ktag = brcnt - 4'(back);
		for (int i = 0; i < exp_q.size(); i++) begin
			row = exp_q[i];
			for (int s = 0; s < rob_pkg::NBANK; s++) begin
				if (tag_killed(ktag, brcnt, tag_q[i][s*4 +: 4])) row.mask[s] = 1'b0;
			end
			exp_q[i] = masked(row);
		end
		brcnt = ktag;
		// Let the last bundle leave the dispatch register first.
		repeat (2) @(posedge clk);
		#2;
		kill_valid = 1'b1;
		kill_tag   = ktag;
		@(posedge clk);
		#2;
		kill_valid = 1'b0;
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			if (held) check(cur_name, {1'b1, held_row}, {com_valid, com_row});
			held     = com_valid && !com_ready;
			held_row = com_row;
			if (tag_valid) begin
				check(cur_name, n_written % ROWS, dis_tag);
				n_written++;
			end
			if (com_valid && com_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: a row committed with no row outstanding", cur_name);
				end else begin
					check(cur_name, exp_q.pop_front(), masked(com_row));
					void'(tag_q.pop_front());
					n_commit++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		int e0;
		int c0;
		rst = 1'b1;
		dis_valid = 1'b0;
		dis_slots = '0;
		wb_valid = 1'b0;
		wb_row = '0;
		wb_slot = '0;
		kill_valid = 1'b0;
		kill_tag = '0;
		com_ready = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < NSTEP; i++) begin
			e0 = errors;
			cur_name = steps[i].name;
			case (steps[i].kind)
				S_DIS:   send_bundles(steps[i].a, 4'(steps[i].b));
				S_WB:    send_writebacks(steps[i].a);
				S_KILL:  send_kill(steps[i].a);
				S_STALL: com_ready = (steps[i].a == 0);
				S_IDLE: begin
					c0 = n_commit;
					repeat (steps[i].a) @(posedge clk);
					#2;
					check(cur_name, c0, n_commit);
					check(cur_name, steps[i].b, com_valid);
				end
				S_DRAIN: begin
					while (exp_q.size() != 0) begin
						@(posedge clk);
						#2;
					end
					check(cur_name, 0, com_valid);
				end
				default: begin
					@(negedge clk);
					if (steps[i].kind == S_FULL) check(cur_name, 0, dis_ready);
					else check(cur_name, 3'b001, {com_valid, tag_valid, dis_ready});
					@(posedge clk);
					#2;
				end
			endcase
			if (errors == e0) $display("%s: ok", cur_name);
			else $display("%s: %0d errors", cur_name, errors - e0);
		end
		$display("steps %0d, checks %0d, commits %0d, errors %0d", NSTEP, checks, n_commit,
			errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/rob_top.sv ====
// ==========================================================================
// Reorder buffer top level.
// Dispatch stage, reorder buffer ring and commit stage.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
	parameter int WIDTH_BANK = 3
) (
	input  wire logic                                   i_clk,
	input  wire logic                                   i_rst,
	input  wire logic                                   i_dis_valid,
	output logic                                        o_dis_ready,
	input  wire rob_pkg::dis_slot_t [rob_pkg::NBANK-1:0] i_dis_slots,
	output logic [WIDTH_BANK-1:0]                       o_dis_tag,
	output logic                                        o_dis_tag_valid,
	input  wire logic                                   i_wb_valid,
	input  wire logic [WIDTH_BANK-1:0]                  i_wb_row,
	input  wire logic [$clog2(rob_pkg::NBANK)-1:0]      i_wb_slot,
	input  wire logic                                   i_kill_valid,
	input  wire logic [rob_pkg::BRM_W-1:0]              i_kill_tag,
	output logic                                        o_com_valid,
	input  wire logic                                   i_com_ready,
	output rob_pkg::com_row_t                           o_com_row
);

	logic                                     kill_valid;
	logic [rob_pkg::BRM_W-1:0]                kill_tag;
	logic [rob_pkg::BRM_W-1:0]                kill_last;
	logic                                     row_valid;
	rob_pkg::rob_entry_t [rob_pkg::NBANK-1:0] row;
	logic                                     rob_ready;
	logic                                     head_ready;
	rob_pkg::com_row_t                        head_row;
	logic                                     head_accept;

	dispatch_stage u_dispatch (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_dis_valid  (i_dis_valid),
		.o_dis_ready  (o_dis_ready),
		.i_dis_slots  (i_dis_slots),
		.i_kill_valid (i_kill_valid),
		.i_kill_tag   (i_kill_tag),
		.o_kill_valid (kill_valid),
		.o_kill_tag   (kill_tag),
		.o_kill_last  (kill_last),
		.o_row_valid  (row_valid),
		.o_row        (row),
		.i_rob_ready  (rob_ready)
	);

	rob #(
		.WIDTH_BANK (WIDTH_BANK)
	) u_rob (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_row_valid     (row_valid),
		.i_row           (row),
		.o_ready         (rob_ready),
		.o_dis_tag       (o_dis_tag),
		.o_dis_tag_valid (o_dis_tag_valid),
		.i_wb_valid      (i_wb_valid),
		.i_wb_row        (i_wb_row),
		.i_wb_slot       (i_wb_slot),
		.i_kill_valid    (kill_valid),
		.i_kill_tag      (kill_tag),
		.i_kill_last     (kill_last),
		.o_head_ready    (head_ready),
		.o_head_row      (head_row),
		.i_head_accept   (head_accept)
	);

	commit_stage u_commit (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_head_ready  (head_ready),
		.i_head_row    (head_row),
		.o_head_accept (head_accept),
		.o_com_valid   (o_com_valid),
		.o_com_row     (o_com_row),
		.i_com_ready   (i_com_ready)
	);

endmodule

`default_nettype wire

// ==== hdl/commit_stage.sv ====
// ==========================================================================
// Commit stage: one-row output register behind the reorder buffer head.
// Takes a row per cycle and holds it under back-pressure.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module commit_stage (
	input  wire logic               i_clk,
	input  wire logic               i_rst,
	input  wire logic               i_head_ready,
	input  wire rob_pkg::com_row_t  i_head_row,
	output logic                    o_head_accept,
	output logic                    o_com_valid,
	output rob_pkg::com_row_t       o_com_row,
	input  wire logic               i_com_ready
);

	logic drain;

	// Register frees up this cycle when its row leaves.
	assign drain         = o_com_valid && i_com_ready;
	assign o_head_accept = i_head_ready && (!o_com_valid || drain);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_com_valid <= 1'b0;
		end else if (o_head_accept) begin
			o_com_valid <= 1'b1;
		end else if (drain) begin
			o_com_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_head_accept) begin
			o_com_row <= i_head_row;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rob.sv ====
// ==========================================================================
// Reorder buffer ring of four-slot rows over four banks.
// Head and tail pointers, occupancy and full detection, the returned
// row tag, head-row readiness and the commit row.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module rob #(
	parameter int WIDTH_BANK = 3
) (
	input  wire logic                                    i_clk,
	input  wire logic                                    i_rst,
	input  wire logic                                    i_row_valid,
	input  wire rob_pkg::rob_entry_t [rob_pkg::NBANK-1:0] i_row,
	output logic                                         o_ready,
	output logic [WIDTH_BANK-1:0]                        o_dis_tag,
	output logic                                         o_dis_tag_valid,
	input  wire logic                                    i_wb_valid,
	input  wire logic [WIDTH_BANK-1:0]                   i_wb_row,
	input  wire logic [$clog2(rob_pkg::NBANK)-1:0]       i_wb_slot,
	input  wire logic                                    i_kill_valid,
	input  wire logic [rob_pkg::BRM_W-1:0]               i_kill_tag,
	input  wire logic [rob_pkg::BRM_W-1:0]               i_kill_last,
	output logic                                         o_head_ready,
	output rob_pkg::com_row_t                            o_head_row,
	input  wire logic                                    i_head_accept
);

	localparam int ROWS = 2 ** WIDTH_BANK;

	logic [WIDTH_BANK-1:0]                    head;
	logic [WIDTH_BANK-1:0]                    tail;
	logic [WIDTH_BANK:0]                      count;
	logic                                     wr;
	logic                                     rd;
	rob_pkg::rob_entry_t [rob_pkg::NBANK-1:0] head_entry;
	logic [rob_pkg::NBANK-1:0]                head_busy;
	logic [rob_pkg::NBANK-1:0]                wb_hit;

	assign o_ready = (count != (WIDTH_BANK+1)'(ROWS));
	assign wr      = i_row_valid && o_ready;
	assign rd      = i_head_accept && o_head_ready;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			head            <= '0;
			tail            <= '0;
			count           <= '0;
			o_dis_tag_valid <= 1'b0;
		end else begin
			o_dis_tag_valid <= wr;
			if (wr) begin
				tail <= tail + 1'b1;
			end
			if (rd) begin
				head <= head + 1'b1;
			end
			case ({wr, rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Row index handed back to the dispatcher.
	always_ff @(posedge i_clk) begin
		if (wr) begin
			o_dis_tag <= tail;
		end
	end

	for (genvar b = 0; b < rob_pkg::NBANK; b++) begin : g_bank
		assign wb_hit[b] = i_wb_valid && (i_wb_slot == b);

		rob_bank #(
			.WIDTH_BANK (WIDTH_BANK)
		) u_bank (
			.i_clk        (i_clk),
			.i_rst        (i_rst),
			.i_we         (wr),
			.i_tail_row   (tail),
			.i_entry      (i_row[b]),
			.i_wb_valid   (wb_hit[b]),
			.i_wb_row     (i_wb_row),
			.i_head_row   (head),
			.o_head_entry (head_entry[b]),
			.o_head_busy  (head_busy[b]),
			.i_kill_valid (i_kill_valid),
			.i_kill_tag   (i_kill_tag),
			.i_kill_last  (i_kill_last)
		);

		assign o_head_row.mask[b] = head_entry[b].val;
		assign o_head_row.prd[b]  = head_entry[b].prd;
	end

	// Killed slots are invalid and never hold the row back.
	assign o_head_ready = (count != '0) && ((o_head_row.mask & head_busy) == '0);

endmodule

`default_nettype wire

// ==== hdl/rob_bank.sv ====
// ==========================================================================
// Reorder buffer bank holding one slot of every row.
// Valid and busy flags, payload storage, writeback clear and
// the cyclic branch kill rule.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module rob_bank #(
	parameter int WIDTH_BANK = 3
) (
	input  wire logic                          i_clk,
	input  wire logic                          i_rst,
	input  wire logic                          i_we,
	input  wire logic [WIDTH_BANK-1:0]         i_tail_row,
	input  wire rob_pkg::rob_entry_t           i_entry,
	input  wire logic                          i_wb_valid,
	input  wire logic [WIDTH_BANK-1:0]         i_wb_row,
	input  wire logic [WIDTH_BANK-1:0]         i_head_row,
	output rob_pkg::rob_entry_t                o_head_entry,
	output logic                               o_head_busy,
	input  wire logic                          i_kill_valid,
	input  wire logic [rob_pkg::BRM_W-1:0]     i_kill_tag,
	input  wire logic [rob_pkg::BRM_W-1:0]     i_kill_last
);

	localparam int ROWS = 2 ** WIDTH_BANK;

	logic [ROWS-1:0]           val;
	logic [ROWS-1:0]           busy;
	rob_pkg::uop_op_e          op_mem    [ROWS];
	logic [rob_pkg::REG_W-1:0] prd_mem   [ROWS];
	logic [rob_pkg::BRM_W-1:0] brtag_mem [ROWS];

	// True when tag lies after kill_tag, up to and including last_tag.
	function automatic logic brkill(
		input logic [rob_pkg::BRM_W-1:0] kill_tag,
		input logic [rob_pkg::BRM_W-1:0] last_tag,
		input logic [rob_pkg::BRM_W-1:0] tag
	);
		logic hit;
		if (kill_tag < last_tag) begin
			hit = (tag > kill_tag) && (tag <= last_tag);
		end else begin
			// Counter wrapped since the killed branch.
			hit = (tag > kill_tag) || (tag <= last_tag);
		end
		return hit;
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			val  <= '0;
			busy <= '0;
		end else begin
			for (int r = 0; r < ROWS; r++) begin
				if (i_kill_valid && brkill(i_kill_tag, i_kill_last, brtag_mem[r])) begin
					val[r] <= 1'b0;
				end
				if (i_wb_valid && i_wb_row == WIDTH_BANK'(r)) begin
					busy[r] <= 1'b0;
				end
			end
			// New entry at the tail overrides the row's old state.
			if (i_we) begin
				val[i_tail_row]  <= i_entry.val;
				busy[i_tail_row] <= i_entry.val;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			op_mem[i_tail_row]    <= i_entry.op;
			prd_mem[i_tail_row]   <= i_entry.prd;
			brtag_mem[i_tail_row] <= i_entry.brtag;
		end
	end

	always_comb begin
		o_head_entry.val   = val[i_head_row];
		o_head_entry.op    = op_mem[i_head_row];
		o_head_entry.prd   = prd_mem[i_head_row];
		o_head_entry.brtag = brtag_mem[i_head_row];
	end

	assign o_head_busy = busy[i_head_row];

endmodule

`default_nettype wire

// ==== hdl/dispatch_stage.sv ====
// ==========================================================================
// Dispatch stage: bundle register in front of the reorder buffer.
// Keeps the branch-tag counter, tags every slot and forwards kills.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
	input  wire logic                                         i_clk,
	input  wire logic                                         i_rst,
	input  wire logic                                         i_dis_valid,
	output logic                                              o_dis_ready,
	input  wire rob_pkg::dis_slot_t [rob_pkg::NBANK-1:0]      i_dis_slots,
	input  wire logic                                         i_kill_valid,
	input  wire logic [rob_pkg::BRM_W-1:0]                    i_kill_tag,
	output logic                                              o_kill_valid,
	output logic [rob_pkg::BRM_W-1:0]                         o_kill_tag,
	output logic [rob_pkg::BRM_W-1:0]                         o_kill_last,
	output logic                                              o_row_valid,
	output rob_pkg::rob_entry_t [rob_pkg::NBANK-1:0]          o_row,
	input  wire logic                                         i_rob_ready
);

	logic                                     row_valid;
	rob_pkg::rob_entry_t [rob_pkg::NBANK-1:0] row_q;
	rob_pkg::rob_entry_t [rob_pkg::NBANK-1:0] row_d;
	logic [rob_pkg::BRM_W-1:0]                brtag_cnt;
	logic [rob_pkg::BRM_W-1:0]                brtag_run;
	logic                                     accept;

	// No new bundle is taken while a kill is being applied.
	assign o_dis_ready = !i_kill_valid && (!row_valid || i_rob_ready);
	assign accept      = i_dis_valid && o_dis_ready;

	// Each slot sees the count of earlier branches in its bundle.
	always_comb begin
		brtag_run = brtag_cnt;
		for (int s = 0; s < rob_pkg::NBANK; s++) begin
			row_d[s].val   = i_dis_slots[s].val;
			row_d[s].op    = i_dis_slots[s].op;
			row_d[s].prd   = i_dis_slots[s].prd;
			row_d[s].brtag = brtag_run;
			if (i_dis_slots[s].val && i_dis_slots[s].op == rob_pkg::OP_BRANCH) begin
				brtag_run = brtag_run + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			row_valid <= 1'b0;
			brtag_cnt <= '0;
		end else if (i_kill_valid) begin
			// Held bundle is younger than the kill and is dropped.
			row_valid <= 1'b0;
			brtag_cnt <= i_kill_tag;
		end else begin
			if (accept) begin
				row_valid <= 1'b1;
				brtag_cnt <= brtag_run;
			end else if (i_rob_ready) begin
				row_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			row_q <= row_d;
		end
	end

	assign o_row_valid  = row_valid && !i_kill_valid;
	assign o_row        = row_q;
	assign o_kill_valid = i_kill_valid;
	assign o_kill_tag   = i_kill_tag;
	assign o_kill_last  = brtag_cnt;

endmodule

`default_nettype wire

// ==== hdl/rob_pkg.sv ====
// ==========================================================================
// Shared definitions for the reorder buffer.
// Slot count, register and branch-tag widths, the micro-op opcode enum
// and the dispatch slot, stored entry and committed row structs.
// ==========================================================================
`default_nettype none

package rob_pkg;

	// Slots per row, one bank each.
	localparam int NBANK = 4;

	// Physical register number width.
	localparam int REG_W = 7;

	// Branch tag width, a wrapping counter.
	localparam int BRM_W = 4;

	typedef enum logic [2:0] {
		OP_ALU    = 3'd0,
		OP_LOAD   = 3'd1,
		OP_STORE  = 3'd2,
		OP_BRANCH = 3'd3
	} uop_op_e;

	// One incoming dispatch slot.
	typedef struct packed {
		logic             val;
		uop_op_e          op;
		logic [REG_W-1:0] prd;
	} dis_slot_t;

	// One stored reorder buffer entry.
	typedef struct packed {
		logic             val;
		uop_op_e          op;
		logic [REG_W-1:0] prd;
		logic [BRM_W-1:0] brtag;
	} rob_entry_t;

	// Retired row as seen by the commit stage.
	typedef struct packed {
		logic [NBANK-1:0]            mask;
		logic [NBANK-1:0][REG_W-1:0] prd;
	} com_row_t;

endpackage

`default_nettype wire
